// ==== Makefile ====
TOP := tb_mps_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f vlog.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "All tests passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== dv/tb_mps_checks.svh ====
`ifndef TB_MPS_CHECKS_SVH
`define TB_MPS_CHECKS_SVH

// One APB transfer with a setup phase and a single access phase
task automatic apb_access(input int idx, input logic wr, input logic [31:0] wdata,
		output apb_rsp_t rsp);
	next_cycle();
	apb.psel    = 1'b1;
	apb.penable = 1'b0;
	apb.pwrite  = wr;
	apb.paddr   = APB_ADDR_W'(idx * 4);
	apb.pwdata  = wdata;
	next_cycle();
	apb.penable = 1'b1;
	@(negedge clk);
	rsp = apb_rsp;   // Zero wait states
	next_cycle();
	apb.psel    = 1'b0;
	apb.penable = 1'b0;
	apb.pwrite  = 1'b0;
endtask

task automatic check_setpoint(input string what, input setpoint_t exp, input setpoint_t act);
	if (act !== exp) begin
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		abort_run();
	end
endtask

task automatic check_header(input string what, input sfp_frame_t exp, input logic [31:0] act);
	logic [31:0] exp_word;
	exp_word = {SFP_SYNC, exp.seq, exp.kind};
	if (act !== exp_word) begin
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp_word, act);
		abort_run();
	end
endtask

task automatic check_payload(input string what, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		abort_run();
	end
endtask

task automatic check_rdata(input string what, input logic [31:0] exp, input apb_rsp_t act);
	if (act.prdata !== exp) begin
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act.prdata);
		abort_run();
	end
endtask

task automatic check_err(input string what, input logic exp, input apb_rsp_t act);
	if (act.pready !== 1'b1) begin
		$display("APB pready was low during %s in %s", what, test_name);
		abort_run();
	end else if (act.pslverr !== exp) begin
		$display("Error %s %s: expected %b, actual %b", test_name, what, exp, act.pslverr);
		abort_run();
	end
endtask

`endif

// ==== dv/tb_mps_core.sv ====
`default_nettype none

module tb_mps_core;
	timeunit 1ns;
	timeprecision 100ps;
	import mps_pkg::*;

	localparam int N_WR     = 40;
	localparam int N_BAD    = 24;
	localparam int N_MASTER = 6;
	localparam int N_SLAVE  = 6;
	localparam int N_STALL  = 10;
	localparam int N_FILL   = 9;
	localparam int N_OFF    = 4;
	// About 12 cycles per APB access pair and under 200 per stalled frame
	localparam int LIMIT_CYCLES = 500 + 12 * (N_WR + N_BAD + 2 * ADC_CH)
		+ 200 * (N_MASTER + N_SLAVE + N_STALL + N_FILL + N_OFF);

	logic        clk;
	logic        rst_n;
	apb_req_t    apb;
	apb_rsp_t    apb_rsp;
	adc_in_t     adc;
	logic [31:0] intl_status;
	logic [31:0] system_fsm;
	logic        frame_tick;
	setpoint_t   setpoint;
	logic [31:0] tx_data;
	logic        tx_valid;
	logic        tx_ready;

	integer      seed = 32'hc18575a8;
	string       test_name = "reset";

	// Reference model state
	logic [31:0]                   regs_m [0:REG_SW];
	logic [ADC_CH-1:0][DATA_W-1:0] hold_m;
	logic [SEQ_W-1:0]              seq_m;
	logic [31:0]                   drop_m;
	logic [31:0]                   sent_m;
	int                            ready_mode;   // 0 high, 1 random, 2 low
	sfp_frame_t                    exp_frames [$];
	int                            word_idx;
	logic                          held_valid;
	logic [31:0]                   held_data;

	mps_core_top UUT (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_apb         (apb),
		.o_apb         (apb_rsp),
		.i_adc         (adc),
		.i_intl_status (intl_status),
		.i_system_fsm  (system_fsm),
		.i_frame_tick  (frame_tick),
		.o_setpoint    (setpoint),
		.o_tx_data     (tx_data),
		.o_tx_valid    (tx_valid),
		.i_tx_ready    (tx_ready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
		frame_tick = 1'b0;
	endtask

	function automatic setpoint_t model_setpoint();
		return {regs_m[REG_MPS_STATUS][3:0], regs_m[REG_SET_C], regs_m[REG_SET_V],
			regs_m[REG_MAX_DUTY], regs_m[REG_MAX_PHASE], regs_m[REG_MAX_FREQ],
			regs_m[REG_MIN_FREQ], regs_m[REG_MIN_C], regs_m[REG_MAX_C],
			regs_m[REG_MIN_V], regs_m[REG_MAX_V], regs_m[REG_SW]};
	endfunction

	function automatic sfp_frame_t model_frame();
		sfp_frame_t f;
		f.seq = seq_m;
		if (regs_m[REG_CTRL][1]) begin
			f.kind = FRAME_TELEMETRY;
			for (int k = 0; k < ADC_CH; k++)
				f.payload[k] = hold_m[k];
			f.payload[ADC_CH]     = intl_status;
			f.payload[ADC_CH + 1] = system_fsm;
		end else begin
			f.kind = FRAME_SETPOINT;
			for (int k = 0; k < FRAME_WORDS; k++)
				f.payload[k] = regs_m[REG_MPS_STATUS + k];   // Status word comes first
		end
		return f;
	endfunction

	`include "tb_mps_checks.svh"

	task automatic write_reg(input int idx, input logic [31:0] d, input logic exp_err);
		apb_rsp_t rsp;
		apb_access(idx, 1'b1, d, rsp);
		check_err("pslverr on write", exp_err, rsp);
		if (!exp_err) begin
			if (idx == REG_CTRL)
				regs_m[idx] = d & 32'h3;
			else if (idx == REG_MPS_STATUS)
				regs_m[idx] = d & 32'hf;
			else
				regs_m[idx] = d;
		end
	endtask

	task automatic read_reg(input int idx, input logic [31:0] exp, input logic exp_err);
		apb_rsp_t rsp;
		apb_access(idx, 1'b0, 32'h0, rsp);
		check_err("pslverr on read", exp_err, rsp);
		if (!exp_err)
			check_rdata($sformatf("read of word %0d", idx), exp, rsp);
	endtask

	// One cycle of ADC, status and ready stimulus plus an optional tick
	task automatic drive_cycle(input logic tick);
		logic [31:0] r;
		next_cycle();
		r           = rand_word();
		intl_status = rand_word();
		system_fsm  = rand_word();
		frame_tick  = tick;
		case (ready_mode)
			0:       tx_ready = 1'b1;
			1:       tx_ready = r[31];
			default: tx_ready = 1'b0;
		endcase
		if (tick && regs_m[REG_CTRL][0]) begin
			if (exp_frames.size() < 5) begin   // Serializer slot plus four FIFO frames
				exp_frames.push_back(model_frame());
				seq_m = seq_m + 1'b1;
			end else begin
				drop_m = drop_m + 1;
			end
		end
		adc.valid = r[ADC_CH-1:0];
		for (int k = 0; k < ADC_CH; k++) begin
			adc.data[k] = rand_word();
			if (adc.valid[k])
				hold_m[k] = adc.data[k];   // Seen by the DUT after the next edge
		end
	endtask

	task automatic run_ticks(input int n, input int max_gap);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			while (exp_frames.size() > 3)
				drive_cycle(1'b0);
			drive_cycle(1'b1);
			r = rand_word();
			repeat (int'(r[7:0]) % max_gap)
				drive_cycle(1'b0);
		end
	endtask

	task automatic drain();
		while (exp_frames.size() != 0)
			drive_cycle(1'b0);
	endtask

	// Serial monitor samples at the negative edge where ready is stable
	always @(negedge clk) begin
		if (rst_n) begin
			if (held_valid && !tx_valid) begin
				$display("o_tx_valid fell before the word %h was accepted", held_data);
				abort_run();
			end else if (held_valid) begin
				check_payload("word held under back-pressure", held_data, tx_data);
			end
			if (tx_valid && tx_ready) begin
				if (exp_frames.size() == 0) begin
					$display("Word %h was sent while no frame was expected", tx_data);
					abort_run();
				end else begin
					if (word_idx == 0)
						check_header("header word", exp_frames[0], tx_data);
					else
						check_payload($sformatf("payload word %0d", word_idx - 1),
							exp_frames[0].payload[word_idx - 1], tx_data);
					if (word_idx == FRAME_WORDS) begin
						void'(exp_frames.pop_front());
						sent_m   = sent_m + 1;
						word_idx = 0;
					end else begin
						word_idx = word_idx + 1;
					end
				end
			end
			held_valid = tx_valid && !tx_ready;
			held_data  = tx_data;
		end
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles without finishing", LIMIT_CYCLES);
		abort_run();
	end

	initial begin
		logic [31:0] r;
		int          idx;
		int          pick;
		rst_n       = 1'b0;
		apb         = '0;
		adc         = '0;
		intl_status = '0;
		system_fsm  = '0;
		frame_tick  = 1'b0;
		tx_ready    = 1'b0;
		for (int k = 0; k <= REG_SW; k++)
			regs_m[k] = '0;
		hold_m     = '0;
		seq_m      = '0;
		drop_m     = '0;
		sent_m     = '0;
		ready_mode = 0;
		word_idx   = 0;
		held_valid = 1'b0;
		held_data  = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		if (tx_valid !== 1'b0) begin
			$display("o_tx_valid is high right after reset");
			abort_run();
		end
		check_setpoint("setpoint after reset", '0, setpoint);
		read_reg(REG_FRAME_CNT, 32'h0, 1'b0);
		read_reg(REG_DROP_CNT, 32'h0, 1'b0);

		test_name = "setpoint_rw";
		for (int n = 0; n < N_WR; n++) begin
			r   = rand_word();
			idx = REG_MPS_STATUS + int'(r[7:0]) % 12;
			write_reg(idx, rand_word(), 1'b0);
			check_setpoint("o_setpoint", model_setpoint(), setpoint);
			read_reg(idx, regs_m[idx], 1'b0);
		end

		test_name = "bad_access";
		for (int n = 0; n < N_BAD; n++) begin
			r = rand_word();
			if (r[4]) begin
				idx = REG_ADC_BASE + int'(r[15:8]) % 12;   // Telemetry and both counters
				write_reg(idx, rand_word(), 1'b1);
			end else begin
				pick = int'(r[15:8]) % 39;
				idx  = (pick < 3) ? REG_SW + 1 + pick : REG_DROP_CNT + 1 + (pick - 3);
				if (r[5])
					write_reg(idx, rand_word(), 1'b1);
				else
					read_reg(idx, 32'h0, 1'b1);
			end
			check_setpoint("setpoint after bad access", model_setpoint(), setpoint);
			read_reg(REG_CTRL, regs_m[REG_CTRL], 1'b0);
		end
		write_reg(REG_FRAME_CNT, rand_word(), 1'b1);
		write_reg(REG_DROP_CNT, rand_word(), 1'b1);
		read_reg(REG_FRAME_CNT, sent_m, 1'b0);
		read_reg(REG_DROP_CNT, drop_m, 1'b0);

		test_name = "master_frames";
		write_reg(REG_CTRL, 32'h1, 1'b0);
		run_ticks(N_MASTER, 20);
		drain();

		test_name = "slave_frames";
		write_reg(REG_CTRL, 32'h3, 1'b0);
		run_ticks(N_SLAVE, 20);
		drain();
		for (int k = 0; k < ADC_CH; k++)
			read_reg(REG_ADC_BASE + k, hold_m[k], 1'b0);

		test_name = "ready_stalls";
		ready_mode = 1;
		run_ticks(N_STALL, 8);
		drain();

		test_name = "fifo_overflow";
		ready_mode = 2;
		for (int n = 0; n < N_FILL; n++) begin
			drive_cycle(1'b1);
			repeat (2)
				drive_cycle(1'b0);
		end
		read_reg(REG_DROP_CNT, drop_m, 1'b0);
		ready_mode = 0;
		drain();
		read_reg(REG_FRAME_CNT, sent_m, 1'b0);

		test_name = "sfp_disabled";
		write_reg(REG_CTRL, 32'h2, 1'b0);
		run_ticks(N_OFF, 4);
		repeat (20)
			drive_cycle(1'b0);   // Window for stray words
		read_reg(REG_FRAME_CNT, sent_m, 1'b0);
		read_reg(REG_DROP_CNT, drop_m, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/mps_core_top.sv ====
`default_nettype none

module mps_core_top (
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  mps_pkg::apb_req_t   i_apb,
	output mps_pkg::apb_rsp_t   o_apb,
	input  mps_pkg::adc_in_t    i_adc,
	input  wire [31:0]          i_intl_status,
	input  wire [31:0]          i_system_fsm,
	input  wire                 i_frame_tick,
	output mps_pkg::setpoint_t  o_setpoint,
	output logic [31:0]         o_tx_data,
	output logic                o_tx_valid,
	input  wire                 i_tx_ready
);
	import mps_pkg::*;

	adc_telem_t  telem;
	sfp_frame_t  push_frame;
	sfp_frame_t  head_frame;
	logic        sfp_en;
	logic        sfp_slave;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	logic        drop;
	logic        frame_done;

	mps_reg_apb u_mps_reg_apb (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_apb        (i_apb),
		.o_apb        (o_apb),
		.i_telem      (telem),
		.i_frame_done (frame_done),
		.i_drop       (drop),
		.o_setpoint   (o_setpoint),
		.o_sfp_en     (sfp_en),
		.o_sfp_slave  (sfp_slave)
	);

	// Setpoints come straight from the bank
	sfp_frame_builder u_sfp_frame_builder (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_adc         (i_adc),
		.i_intl_status (i_intl_status),
		.i_system_fsm  (i_system_fsm),
		.i_frame_tick  (i_frame_tick),
		.i_sfp_en      (sfp_en),
		.i_sfp_slave   (sfp_slave),
		.i_setpoint    (o_setpoint),
		.i_full        (full),
		.o_telem       (telem),
		.o_push        (push),
		.o_frame       (push_frame),
		.o_drop        (drop)
	);

	sfp_frame_fifo u_sfp_frame_fifo (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_push  (push),
		.i_frame (push_frame),
		.i_pop   (pop),
		.o_frame (head_frame),
		.o_full  (full),
		.o_empty (empty)
	);

	sfp_tx_serializer u_sfp_tx_serializer (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_empty      (empty),
		.i_frame      (head_frame),
		.o_pop        (pop),
		.o_tx_data    (o_tx_data),
		.o_tx_valid   (o_tx_valid),
		.i_tx_ready   (i_tx_ready),
		.o_frame_done (frame_done)
	);

endmodule

`default_nettype wire

// ==== logic/mps_pkg.sv ====
`default_nettype none

package mps_pkg;

	localparam int DATA_W           = 32;
	localparam int ADC_CH           = 10;
	localparam int FRAME_WORDS      = 12;
	localparam int FRAME_FIFO_DEPTH = 4;
	localparam int SEQ_W            = 8;
	localparam logic [15:0] SFP_SYNC = 16'hC5A3;   // Upper half of every header word

	localparam int APB_ADDR_W = 8;
	localparam int ADC_IDX_W  = $clog2(ADC_CH);
	localparam int WORD_IDX_W = $clog2(FRAME_WORDS);
	localparam int FIFO_PTR_W = $clog2(FRAME_FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FRAME_FIFO_DEPTH + 1);

	// Word indexes where the byte address is index * 4
	localparam int REG_CTRL       = 0;    // [0] sfp enable, [1] slave select
	localparam int REG_MPS_STATUS = 1;
	localparam int REG_SET_C      = 2;
	localparam int REG_SET_V      = 3;
	localparam int REG_MAX_DUTY   = 4;
	localparam int REG_MAX_PHASE  = 5;
	localparam int REG_MAX_FREQ   = 6;
	localparam int REG_MIN_FREQ   = 7;
	localparam int REG_MIN_C      = 8;
	localparam int REG_MAX_C      = 9;
	localparam int REG_MIN_V      = 10;
	localparam int REG_MAX_V      = 11;
	localparam int REG_SW         = 12;   // Deadband high, switching freq low
	localparam int REG_ADC_BASE   = 16;
	localparam int REG_FRAME_CNT  = 26;
	localparam int REG_DROP_CNT   = 27;

	typedef enum logic [7:0] {
		FRAME_TELEMETRY = 8'h01,
		FRAME_SETPOINT  = 8'h02
	} frame_kind_e;

	typedef enum logic [1:0] {
		S_IDLE,
		S_HEADER,
		S_PAYLOAD
	} ser_state_e;

	// Field order follows the setpoint frame payload
	typedef struct packed {
		logic [3:0]        mps_status;
		logic [DATA_W-1:0] set_c;
		logic [DATA_W-1:0] set_v;
		logic [DATA_W-1:0] max_duty;
		logic [DATA_W-1:0] max_phase;
		logic [DATA_W-1:0] max_freq;
		logic [DATA_W-1:0] min_freq;
		logic [DATA_W-1:0] min_c;
		logic [DATA_W-1:0] max_c;
		logic [DATA_W-1:0] min_v;
		logic [DATA_W-1:0] max_v;
		logic [15:0]       deadband;
		logic [15:0]       sw_freq;
	} setpoint_t;

	typedef struct packed {
		logic [DATA_W-1:0] c;
		logic [DATA_W-1:0] v;
		logic [DATA_W-1:0] dc_c;
		logic [DATA_W-1:0] dc_v;
		logic [DATA_W-1:0] phase_r;
		logic [DATA_W-1:0] phase_s;
		logic [DATA_W-1:0] phase_t;
		logic [DATA_W-1:0] igbt_t;
		logic [DATA_W-1:0] i_inductor_t;
		logic [DATA_W-1:0] o_inductor_t;
	} adc_telem_t;

	// Channel index 0 is c as in adc_telem_t
	typedef struct packed {
		logic [ADC_CH-1:0][DATA_W-1:0] data;
		logic [ADC_CH-1:0]             valid;
	} adc_in_t;

	typedef struct packed {
		frame_kind_e                        kind;
		logic [SEQ_W-1:0]                   seq;
		logic [FRAME_WORDS-1:0][DATA_W-1:0] payload;   // payload[0] goes out first
	} sfp_frame_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [DATA_W-1:0]     pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/mps_reg_apb.sv ====
`default_nettype none

module mps_reg_apb (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  mps_pkg::apb_req_t    i_apb,
	output mps_pkg::apb_rsp_t    o_apb,
	input  mps_pkg::adc_telem_t  i_telem,
	input  wire                  i_frame_done,
	input  wire                  i_drop,
	output mps_pkg::setpoint_t   o_setpoint,
	output logic                 o_sfp_en,
	output logic                 o_sfp_slave
);
	import mps_pkg::*;

	setpoint_t                     sp_q;
	logic                          sfp_en_q;
	logic                          sfp_slave_q;
	logic [DATA_W-1:0]             frame_cnt_q;
	logic [DATA_W-1:0]             drop_cnt_q;
	logic [ADC_CH-1:0][DATA_W-1:0] telem_w;
	logic                          access;
	logic                          wr_en;
	int                            widx;
	int                            adc_off;
	logic                          in_adc;
	logic [DATA_W-1:0]             rd_data;
	logic                          mapped;
	logic                          rd_only;

	assign access  = i_apb.psel & i_apb.penable;
	assign wr_en   = access & i_apb.pwrite;
	assign widx    = int'(i_apb.paddr[APB_ADDR_W-1:2]);
	assign adc_off = widx - REG_ADC_BASE;
	assign in_adc  = (widx >= REG_ADC_BASE) && (widx < REG_ADC_BASE + ADC_CH);
	assign telem_w = i_telem;   // Channel c lands in the top word

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sp_q        <= '0;
			sfp_en_q    <= 1'b0;
			sfp_slave_q <= 1'b0;
		end else if (wr_en) begin
			// Read-only and unmapped indexes fall through untouched
			case (widx)
				REG_CTRL: begin
					sfp_en_q    <= i_apb.pwdata[0];
					sfp_slave_q <= i_apb.pwdata[1];
				end
				REG_MPS_STATUS: sp_q.mps_status <= i_apb.pwdata[3:0];
				REG_SET_C:      sp_q.set_c      <= i_apb.pwdata;
				REG_SET_V:      sp_q.set_v      <= i_apb.pwdata;
				REG_MAX_DUTY:   sp_q.max_duty   <= i_apb.pwdata;
				REG_MAX_PHASE:  sp_q.max_phase  <= i_apb.pwdata;
				REG_MAX_FREQ:   sp_q.max_freq   <= i_apb.pwdata;
				REG_MIN_FREQ:   sp_q.min_freq   <= i_apb.pwdata;
				REG_MIN_C:      sp_q.min_c      <= i_apb.pwdata;
				REG_MAX_C:      sp_q.max_c      <= i_apb.pwdata;
				REG_MIN_V:      sp_q.min_v      <= i_apb.pwdata;
				REG_MAX_V:      sp_q.max_v      <= i_apb.pwdata;
				REG_SW: begin
					sp_q.deadband <= i_apb.pwdata[31:16];
					sp_q.sw_freq  <= i_apb.pwdata[15:0];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			frame_cnt_q <= '0;
			drop_cnt_q  <= '0;
		end else begin
			if (i_frame_done)
				frame_cnt_q <= frame_cnt_q + 1'b1;
			if (i_drop)
				drop_cnt_q <= drop_cnt_q + 1'b1;
		end
	end

	always_comb begin
		rd_data = '0;
		mapped  = 1'b1;
		rd_only = 1'b0;
		case (widx)
			REG_CTRL:       rd_data = DATA_W'({sfp_slave_q, sfp_en_q});
			REG_MPS_STATUS: rd_data = DATA_W'(sp_q.mps_status);
			REG_SET_C:      rd_data = sp_q.set_c;
			REG_SET_V:      rd_data = sp_q.set_v;
			REG_MAX_DUTY:   rd_data = sp_q.max_duty;
			REG_MAX_PHASE:  rd_data = sp_q.max_phase;
			REG_MAX_FREQ:   rd_data = sp_q.max_freq;
			REG_MIN_FREQ:   rd_data = sp_q.min_freq;
			REG_MIN_C:      rd_data = sp_q.min_c;
			REG_MAX_C:      rd_data = sp_q.max_c;
			REG_MIN_V:      rd_data = sp_q.min_v;
			REG_MAX_V:      rd_data = sp_q.max_v;
			REG_SW:         rd_data = {sp_q.deadband, sp_q.sw_freq};
			REG_FRAME_CNT: begin
				rd_data = frame_cnt_q;
				rd_only = 1'b1;
			end
			REG_DROP_CNT: begin
				rd_data = drop_cnt_q;
				rd_only = 1'b1;
			end
			default: begin
				if (in_adc) begin
					rd_data = telem_w[ADC_IDX_W'(ADC_CH - 1 - adc_off)];
					rd_only = 1'b1;
				end else begin
					mapped = 1'b0;
				end
			end
		endcase
	end

	assign o_apb.prdata  = rd_data;
	assign o_apb.pready  = 1'b1;   // Zero wait states
	assign o_apb.pslverr = access & (~mapped | (i_apb.pwrite & rd_only));

	assign o_setpoint  = sp_q;
	assign o_sfp_en    = sfp_en_q;
	assign o_sfp_slave = sfp_slave_q;

endmodule

`default_nettype wire

// ==== logic/sfp_frame_builder.sv ====
`default_nettype none

module sfp_frame_builder (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  mps_pkg::adc_in_t     i_adc,
	input  wire [31:0]           i_intl_status,
	input  wire [31:0]           i_system_fsm,
	input  wire                  i_frame_tick,
	input  wire                  i_sfp_en,
	input  wire                  i_sfp_slave,
	input  mps_pkg::setpoint_t   i_setpoint,
	input  wire                  i_full,
	output mps_pkg::adc_telem_t  o_telem,
	output logic                 o_push,
	output mps_pkg::sfp_frame_t  o_frame,
	output logic                 o_drop
);
	import mps_pkg::*;

	logic [ADC_CH-1:0][DATA_W-1:0] hold_q;
	logic [SEQ_W-1:0]              seq_q;
	logic                          tick_en;
	sfp_frame_t                    frame;

	// Each channel keeps its last valid sample
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hold_q <= '0;
		end else begin
			for (int k = 0; k < ADC_CH; k++) begin
				if (i_adc.valid[k])
					hold_q[k] <= i_adc.data[k];
			end
		end
	end

	assign o_telem = {hold_q[0], hold_q[1], hold_q[2], hold_q[3], hold_q[4],
	                  hold_q[5], hold_q[6], hold_q[7], hold_q[8], hold_q[9]};

	always_comb begin
		frame.seq = seq_q;
		if (i_sfp_slave) begin
			frame.kind = FRAME_TELEMETRY;
			for (int k = 0; k < ADC_CH; k++)
				frame.payload[k] = hold_q[k];
			frame.payload[ADC_CH]     = i_intl_status;
			frame.payload[ADC_CH + 1] = i_system_fsm;
		end else begin
			frame.kind        = FRAME_SETPOINT;
			frame.payload[0]  = DATA_W'(i_setpoint.mps_status);
			frame.payload[1]  = i_setpoint.set_c;
			frame.payload[2]  = i_setpoint.set_v;
			frame.payload[3]  = i_setpoint.max_duty;
			frame.payload[4]  = i_setpoint.max_phase;
			frame.payload[5]  = i_setpoint.max_freq;
			frame.payload[6]  = i_setpoint.min_freq;
			frame.payload[7]  = i_setpoint.min_c;
			frame.payload[8]  = i_setpoint.max_c;
			frame.payload[9]  = i_setpoint.min_v;
			frame.payload[10] = i_setpoint.max_v;
			frame.payload[11] = {i_setpoint.deadband, i_setpoint.sw_freq};
		end
	end

	assign tick_en = i_frame_tick & i_sfp_en;   // Disabled ticks are ignored entirely
	assign o_push  = tick_en & ~i_full;
	assign o_drop  = tick_en & i_full;
	assign o_frame = frame;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			seq_q <= '0;
		else if (o_push)
			seq_q <= seq_q + 1'b1;
	end

endmodule

`default_nettype wire

// ==== logic/sfp_frame_fifo.sv ====
`default_nettype none

module sfp_frame_fifo (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  wire                  i_push,
	input  mps_pkg::sfp_frame_t  i_frame,
	input  wire                  i_pop,
	output mps_pkg::sfp_frame_t  o_frame,
	output logic                 o_full,
	output logic                 o_empty
);
	import mps_pkg::*;

	sfp_frame_t              mem_q [FRAME_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]   wr_ptr_q;
	logic [FIFO_PTR_W-1:0]   rd_ptr_q;
	logic [FIFO_CNT_W-1:0]   cnt_q;
	logic [FIFO_CNT_W-1:0]   cnt_nxt;
	logic                    full_q;
	logic                    empty_q;
	logic                    do_push;
	logic                    do_pop;

	assign do_push = i_push & ~full_q;
	assign do_pop  = i_pop & ~empty_q;

	always_comb begin
		case ({do_push, do_pop})
			2'b10:   cnt_nxt = cnt_q + 1'b1;
			2'b01:   cnt_nxt = cnt_q - 1'b1;
			default: cnt_nxt = cnt_q;   // Both or neither
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem_q[wr_ptr_q] <= i_frame;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
			full_q   <= 1'b0;
			empty_q  <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FRAME_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FRAME_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			cnt_q   <= cnt_nxt;
			full_q  <= (cnt_nxt == FIFO_CNT_W'(FRAME_FIFO_DEPTH));
			empty_q <= (cnt_nxt == '0);
		end
	end

	assign o_frame = mem_q[rd_ptr_q];
	assign o_full  = full_q;
	assign o_empty = empty_q;

endmodule

`default_nettype wire

// ==== logic/sfp_tx_serializer.sv ====
`default_nettype none

module sfp_tx_serializer (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  wire                  i_empty,
	input  mps_pkg::sfp_frame_t  i_frame,
	output logic                 o_pop,
	output logic [31:0]          o_tx_data,
	output logic                 o_tx_valid,
	input  wire                  i_tx_ready,
	output logic                 o_frame_done
);
	import mps_pkg::*;

	ser_state_e              state_q;
	sfp_frame_t              frame_q;
	logic [WORD_IDX_W-1:0]   idx_q;
	logic                    done_q;
	logic                    last_word;

	assign o_pop      = (state_q == S_IDLE) & ~i_empty;
	assign o_tx_valid = (state_q != S_IDLE);
	assign last_word  = (idx_q == WORD_IDX_W'(FRAME_WORDS - 1));

	// Frame slot loads on a pop
	always_ff @(posedge i_clk) begin
		if (o_pop)
			frame_q <= i_frame;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= S_IDLE;
			idx_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (o_pop)
						state_q <= S_HEADER;
				end
				S_HEADER: begin
					if (i_tx_ready) begin
						state_q <= S_PAYLOAD;
						idx_q   <= '0;
					end
				end
				S_PAYLOAD: begin
					if (i_tx_ready) begin
						if (last_word) begin
							state_q <= S_IDLE;
							done_q  <= 1'b1;
						end else begin
							idx_q <= idx_q + 1'b1;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Word stays put until ready, since state and index only move on accept
	always_comb begin
		case (state_q)
			S_HEADER:  o_tx_data = {SFP_SYNC, frame_q.seq, frame_q.kind};
			S_PAYLOAD: o_tx_data = frame_q.payload[idx_q];
			default:   o_tx_data = '0;
		endcase
	end

	assign o_frame_done = done_q;

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
logic/mps_pkg.sv
logic/mps_reg_apb.sv
logic/sfp_frame_builder.sv
logic/sfp_frame_fifo.sv
logic/sfp_tx_serializer.sv
logic/mps_core_top.sv
dv/tb_mps_core.sv
